/* common/pe_macros.svh */
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// array size
// rows share one pixel lane each
`define PE_ROWS 4
// columns share one weight lane each
`define PE_COLS 4

// pixel word width, signed
`define PE_X_BITS 8

// weight word width, signed
`define PE_K_BITS 8

// full product width, never truncated
`define PE_M_BITS (`PE_X_BITS + `PE_K_BITS)

// accumulator and output width
// sums wrap in two's complement here
`define PE_Y_BITS 24

`endif

/* common/pe_types_pkg.sv */
`include "pe_macros.svh"

package pe_types_pkg;

  // scalar words of the data path
  typedef logic signed [`PE_X_BITS-1:0] pixel_t;
  typedef logic signed [`PE_K_BITS-1:0] weight_t;
  typedef logic signed [`PE_M_BITS-1:0] product_t;
  typedef logic signed [`PE_Y_BITS-1:0] sum_t;

  // one pixel per row, broadcast to every column
  typedef pixel_t [`PE_ROWS-1:0] pixel_vec_t;

  // one weight per column, shared by every row
  typedef weight_t [`PE_COLS-1:0] weight_vec_t;

  // one output beat, a full column of sums
  typedef sum_t [`PE_ROWS-1:0] sum_col_t;

  // finished block, indexed by column first
  typedef sum_col_t [`PE_COLS-1:0] sum_block_t;

endpackage

/* common/pe_ctrl_pkg.sv */
`include "pe_macros.svh"

package pe_ctrl_pkg;

  // pointer width for the drain column
  // a single column still needs one bit
  localparam int unsigned COL_IDX_BITS = (`PE_COLS > 1) ? $clog2(`PE_COLS) : 1;

  typedef logic [COL_IDX_BITS-1:0] col_idx_t;

  // output shifter states
  // IDLE waits for a block, DRAIN sends it out
  typedef enum logic {
    IDLE,
    DRAIN
  } drain_state_e;

endpackage

/* rtl/pe_input_stage.sv */
`timescale 1ns/1ps

module pe_input_stage
  import pe_types_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  // global enable, also seen outside as s_ready
  input  logic        advance,
  input  logic        s_valid,
  input  pixel_vec_t  s_pixels,
  input  weight_vec_t s_weights,
  input  logic        s_last,
  output logic        in_valid,
  output logic        in_last,
  output pixel_vec_t  in_pixels,
  output weight_vec_t in_weights
);

  // beat accepted on this edge
  logic load_beat;

  assign load_beat = advance && s_valid;

  // control flags
  // a bubble is registered as well so in_valid drops when the source idles
  always_ff @(posedge clk) begin
    if (!resetn) begin
      in_valid <= 1'b0;
      in_last  <= 1'b0;
    end else if (advance) begin
      in_valid <= s_valid;
      // last only means something on a valid beat
      in_last  <= s_valid && s_last;
    end
  end

  // row pixel register
  // pixels go to every column at once, no skew
  always_ff @(posedge clk) begin
    if (load_beat) begin
      in_pixels <= s_pixels;
    end
  end

  // column weight register
  always_ff @(posedge clk) begin
    if (load_beat) begin
      in_weights <= s_weights;
    end
  end

endmodule

/* pe_array/pe_mac_array.sv */
`timescale 1ns/1ps
`include "pe_macros.svh"

module pe_mac_array
  import pe_types_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        advance,
  input  logic        in_valid,
  input  logic        in_last,
  input  pixel_vec_t  in_pixels,
  input  weight_vec_t in_weights,
  input  logic        blk_take,
  output logic        blk_valid,
  output sum_block_t  blk_data
);

  // flags that travel with the product register
  logic mul_valid;
  logic mul_last;
  // first beat of a packet starts from zero
  logic bypass;
  // accumulators update on a valid product
  logic acc_en;
  // last product of a packet lands this edge
  logic blk_done;

  assign acc_en   = advance && mul_valid;
  assign blk_done = acc_en && mul_last;

  // stage one control
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mul_valid <= 1'b0;
      mul_last  <= 1'b0;
    end else if (advance) begin
      mul_valid <= in_valid;
      mul_last  <= in_valid && in_last;
    end
  end

  // bypass is armed after reset and after every last beat
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bypass <= 1'b1;
    end else if (acc_en) begin
      bypass <= mul_last;
    end
  end

  // finished block flag
  // a new block wins over a take in the same cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      blk_valid <= 1'b0;
    end else if (blk_done) begin
      blk_valid <= 1'b1;
    end else if (blk_take) begin
      blk_valid <= 1'b0;
    end
  end

  // ROWS x COLS processing elements
  for (genvar r = 0; r < `PE_ROWS; r++) begin : g_row
    for (genvar c = 0; c < `PE_COLS; c++) begin : g_col
      product_t prod_q;
      sum_t     prod_ext;
      sum_t     acc_q;
      sum_t     acc_next;
      sum_t     blk_q;

      // stage one, full width signed product
      always_ff @(posedge clk) begin
        if (advance && in_valid) begin
          prod_q <= $signed(in_pixels[r]) * $signed(in_weights[c]);
        end
      end

      // sign extend to the sum width
      assign prod_ext = sum_t'(prod_q);
      assign acc_next = bypass ? prod_ext : acc_q + prod_ext;

      // stage two, running sum
      always_ff @(posedge clk) begin
        if (acc_en) begin
          acc_q <= acc_next;
        end
      end

      // finished sum is copied out so the next packet can start
      always_ff @(posedge clk) begin
        if (blk_done) begin
          blk_q <= acc_next;
        end
      end

      assign blk_data[c][r] = blk_q;
    end
  end

  // the top level must freeze the pipe while a block waits
  a_no_overwrite : assert property (
    @(posedge clk) disable iff (!resetn)
    (blk_valid && !blk_take) |-> !blk_done
  );

endmodule

/* pe_array/pe_out_shifter.sv */
`timescale 1ns/1ps
`include "pe_macros.svh"

module pe_out_shifter
  import pe_types_pkg::*;
  import pe_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       blk_valid,
  input  sum_block_t blk_data,
  input  logic       m_ready,
  output logic       blk_take,
  output logic       m_valid,
  output sum_col_t   m_data,
  output logic       m_last
);

  drain_state_e state;
  // column currently on m_data
  col_idx_t     col_ptr;
  // captured block, drained column 0 first
  sum_block_t   blk_q;
  // output handshake
  logic         out_fire;
  logic         last_col;

  // a block is only taken while nothing is being drained
  assign blk_take = (state == IDLE) && blk_valid;

  assign last_col = col_ptr == col_idx_t'(`PE_COLS - 1);
  assign m_valid  = state == DRAIN;
  assign out_fire = m_valid && m_ready;

  // output mux over the captured columns
  assign m_data = blk_q[col_ptr];
  assign m_last = m_valid && last_col;

  // drain FSM
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= IDLE;
      col_ptr <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (blk_take) begin
            state   <= DRAIN;
            col_ptr <= '0;
          end
        end
        DRAIN: begin
          // one column per accepted beat
          if (out_fire) begin
            if (last_col) begin
              state <= IDLE;
            end else begin
              col_ptr <= col_ptr + 1'b1;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // block capture, one cycle after the take
  always_ff @(posedge clk) begin
    if (blk_take) begin
      blk_q <= blk_data;
    end
  end

  // stream rule on the output side
  a_m_stable : assert property (
    @(posedge clk) disable iff (!resetn)
    (m_valid && !m_ready) |=> m_valid && $stable(m_data) && $stable(m_last)
  );

endmodule

/* rtl/proc_engine.sv */
`timescale 1ns/1ps

module proc_engine
  import pe_types_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        s_valid,
  input  pixel_vec_t  s_pixels,
  input  weight_vec_t s_weights,
  input  logic        s_last,
  input  logic        m_ready,
  output logic        s_ready,
  output logic        m_valid,
  output sum_col_t    m_data,
  output logic        m_last
);

  // global enable for input and mac stages
  logic        advance;
  logic        in_valid;
  logic        in_last;
  pixel_vec_t  in_pixels;
  weight_vec_t in_weights;
  // block hand-off between array and shifter
  logic        blk_valid;
  logic        blk_take;
  sum_block_t  blk_data;

  // the pipe moves unless a finished block is stuck behind a drain
  assign advance = !blk_valid || blk_take;
  assign s_ready = advance;

  pe_input_stage i_input_stage (
    .clk        (clk),
    .resetn     (resetn),
    .advance    (advance),
    .s_valid    (s_valid),
    .s_pixels   (s_pixels),
    .s_weights  (s_weights),
    .s_last     (s_last),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_pixels  (in_pixels),
    .in_weights (in_weights)
  );

  pe_mac_array i_mac_array (
    .clk        (clk),
    .resetn     (resetn),
    .advance    (advance),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_pixels  (in_pixels),
    .in_weights (in_weights),
    .blk_take   (blk_take),
    .blk_valid  (blk_valid),
    .blk_data   (blk_data)
  );

  pe_out_shifter i_out_shifter (
    .clk       (clk),
    .resetn    (resetn),
    .blk_valid (blk_valid),
    .blk_data  (blk_data),
    .m_ready   (m_ready),
    .blk_take  (blk_take),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_last    (m_last)
  );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic resetn
);

  // free running clock, half period per phase
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

  // reset low for the first cycles
  // released on a rising edge so the DUT sees a clean synchronous release
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

/* sim/proc_engine_tb.sv */
`timescale 1ns/1ps
`include "pe_macros.svh"

module proc_engine_tb
  import pe_types_pkg::*;
();

  localparam int DRV_TIMEOUT = 200;
  // long enough to cover the 600 beat packet before its block appears
  localparam int MON_TIMEOUT = 1000;
  localparam int NUM_PKTS    = 10;

  // one row per packet
  // columns: beats, idle cycles before it, random m_ready, extreme values
  localparam int PKT_TBL [NUM_PKTS][4] = '{
    '{5,   0,  0, 0},
    '{1,   12, 0, 0},
    '{1,   0,  0, 0},
    '{3,   0,  0, 0},
    '{2,   0,  0, 0},
    '{6,   3,  1, 0},
    '{4,   0,  1, 0},
    '{1,   0,  1, 0},
    '{600, 2,  1, 1},
    '{2,   0,  1, 0}
  };

  logic        clk;
  logic        resetn;
  logic        s_valid;
  pixel_vec_t  s_pixels;
  weight_vec_t s_weights;
  logic        s_last;
  logic        m_ready;
  logic        s_ready;
  logic        m_valid;
  sum_col_t    m_data;
  logic        m_last;

  logic [31:0] lfsr;
  int          pkts_sent;

  // expanded input beats
  pixel_vec_t  beat_pix[$];
  weight_vec_t beat_wgt[$];
  bit          beat_last[$];
  int          beat_gap[$];
  // model output, ROWS sums per column, columns in drain order
  longint      exp_sum[$];
  bit          exp_bp[$];

  tb_clock_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (5)
  ) i_clock_gen (
    .clk    (clk),
    .resetn (resetn)
  );

  proc_engine i_proc_engine (
    .clk       (clk),
    .resetn    (resetn),
    .s_valid   (s_valid),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .s_last    (s_last),
    .m_ready   (m_ready),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_last    (m_last)
  );

  // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // two's complement wrap at the accumulator width
  function automatic longint wrap_sum(input longint v);
    longint m;
    m = longint'(1) << `PE_Y_BITS;
    v = v % m;
    if (v < 0) v += m;
    if (v >= (m >> 1)) v -= m;
    return v;
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what,
               $signed(actual), $signed(expected));
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_stall(input string what);
    $display("TIMEOUT at %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "handshake timeout");
  endtask

  // expand the packet table into beats and run the sum model
  task automatic build_table();
    longint      acc [`PE_ROWS][`PE_COLS];
    pixel_vec_t  px;
    weight_vec_t wt;
    for (int p = 0; p < NUM_PKTS; p++) begin
      acc = '{default: 0};
      for (int b = 0; b < PKT_TBL[p][0]; b++) begin
        for (int r = 0; r < `PE_ROWS; r++) begin
          // extremes alternate between most negative and most positive
          if (PKT_TBL[p][3] != 0) begin
            px[r] = (r % 2 == 0) ? {1'b1, {(`PE_X_BITS-1){1'b0}}}
                                 : {1'b0, {(`PE_X_BITS-1){1'b1}}};
          end else begin
            px[r] = pixel_t'(take_bits(`PE_X_BITS));
          end
        end
        for (int c = 0; c < `PE_COLS; c++) begin
          if (PKT_TBL[p][3] != 0) begin
            wt[c] = (c % 2 == 0) ? {1'b1, {(`PE_K_BITS-1){1'b0}}}
                                 : {1'b0, {(`PE_K_BITS-1){1'b1}}};
          end else begin
            wt[c] = weight_t'(take_bits(`PE_K_BITS));
          end
        end
        // every PE adds its row pixel times its column weight
        for (int r = 0; r < `PE_ROWS; r++) begin
          for (int c = 0; c < `PE_COLS; c++) begin
            acc[r][c] += longint'(px[r]) * longint'(wt[c]);
          end
        end
        beat_pix.push_back(px);
        beat_wgt.push_back(wt);
        beat_last.push_back(b == PKT_TBL[p][0] - 1);
        beat_gap.push_back((b == 0) ? PKT_TBL[p][1] : 0);
      end
      // column 0 drains first
      for (int c = 0; c < `PE_COLS; c++) begin
        for (int r = 0; r < `PE_ROWS; r++) begin
          exp_sum.push_back(wrap_sum(acc[r][c]));
        end
        exp_bp.push_back(PKT_TBL[p][2] != 0);
      end
    end
  endtask

  // source side, s_valid held until taken and never gated by s_ready
  task automatic drive_beats();
    int wait_cnt;
    bit accepted;
    for (int i = 0; i < beat_last.size(); i++) begin
      s_valid = 1'b0;
      repeat (beat_gap[i]) begin
        @(posedge clk);
        #1;
      end
      s_valid   = 1'b1;
      s_pixels  = beat_pix[i];
      s_weights = beat_wgt[i];
      s_last    = beat_last[i];
      wait_cnt  = 0;
      accepted  = 1'b0;
      while (!accepted) begin
        // s_ready only moves on clock edges, mid cycle it is settled
        @(negedge clk);
        accepted = s_ready;
        @(posedge clk);
        #1;
        wait_cnt++;
        if (!accepted && wait_cnt >= DRV_TIMEOUT) begin
          abort_stall("s_ready stayed low and an input beat was never taken");
        end
      end
      if (beat_last[i]) pkts_sent++;
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  // sink side, m_ready from the LFSR on back-pressure packets
  task automatic collect_beats();
    int       wait_cnt;
    bit       fire;
    bit       stalled;
    sum_col_t held_data;
    logic     held_last;
    stalled = 1'b0;
    for (int k = 0; k < exp_bp.size(); k++) begin
      wait_cnt = 0;
      fire     = 1'b0;
      while (!fire) begin
        m_ready = exp_bp[k] ? (take_bits(1) != 0) : 1'b1;
        @(negedge clk);
        if (pkts_sent == 0) begin
          check_equal(64'(m_valid), 64'(0), "m_valid before the first packet ended");
        end
        // a stalled beat must hold
        if (stalled) begin
          check_equal(64'(m_valid), 64'(1), "m_valid dropped during a stall");
          for (int r = 0; r < `PE_ROWS; r++) begin
            check_equal(64'(m_data[r]), 64'(held_data[r]), "m_data changed during a stall");
          end
          check_equal(64'(m_last), 64'(held_last), "m_last changed during a stall");
        end
        stalled   = m_valid && !m_ready;
        held_data = m_data;
        held_last = m_last;
        fire      = m_valid && m_ready;
        if (fire) begin
          for (int r = 0; r < `PE_ROWS; r++) begin
            check_equal(64'(m_data[r]), 64'(exp_sum.pop_front()),
                        $sformatf("packet %0d column %0d row %0d sum", k / `PE_COLS,
                                  k % `PE_COLS, r));
          end
          check_equal(64'(m_last), 64'(k % `PE_COLS == `PE_COLS - 1),
                      $sformatf("m_last on column %0d", k % `PE_COLS));
        end
        @(posedge clk);
        #1;
        wait_cnt++;
        if (!fire && wait_cnt >= MON_TIMEOUT) begin
          abort_stall("m_valid never came up for the next output column");
        end
      end
    end
    // nothing left to drain
    m_ready = 1'b1;
    @(negedge clk);
    check_equal(64'(m_valid), 64'(0), "m_valid after the last block");
  endtask

  initial begin
    int wait_cnt;
    s_valid   = 1'b0;
    s_pixels  = '0;
    s_weights = '0;
    s_last    = 1'b0;
    m_ready   = 1'b0;
    lfsr      = 32'h27e1;
    pkts_sent = 0;
    build_table();
    wait_cnt = 0;
    while (resetn !== 1'b1) begin
      @(posedge clk);
      #1;
      wait_cnt++;
      if (wait_cnt > 20) begin
        abort_stall("resetn was never released");
      end
    end
    check_equal(64'(s_ready), 64'(1), "s_ready after reset");
    check_equal(64'(m_valid), 64'(0), "m_valid after reset");
    fork
      drive_beats();
      collect_beats();
    join
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/pe_types_pkg.sv
common/pe_ctrl_pkg.sv
rtl/pe_input_stage.sv
pe_array/pe_mac_array.sv
pe_array/pe_out_shifter.sv
rtl/proc_engine.sv
sim/tb_clock_gen.sv
sim/proc_engine_tb.sv

/* Makefile */
TOP = proc_engine_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module proc_engine
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  -f files.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
	  echo "RESULT: FAIL, run ended without a verdict"; exit 1; \
	else \
	  echo "RESULT: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
